/* design/jenc_settings.svh */
`ifndef JENC_SETTINGS_SVH
`define JENC_SETTINGS_SVH

// Signed DCT coefficient at the input.
`define JENC_DW 15

// Signed coefficient after quantization.
`define JENC_QW 11

// 8 symbol bits plus up to 11 amplitude bits.
`define JENC_CODE_MAX 19

// Output byte counter.
`define JENC_SIZE_W 20

`endif

/* design/jenc_pkg.sv */
package jenc_pkg;

    // Index of a coefficient inside its 8x8 block, zigzag order.
    typedef logic [5:0] coef_pos_t;

    // Fixed point reciprocal, 16 fractional bits.
    typedef logic [15:0] recip_t;

    // Luminance quantization divisors, listed in zigzag order.
    localparam logic [7:0] qtable [64] = '{
        8'd16,  8'd11,  8'd12,  8'd14,  8'd12,  8'd10,  8'd16,  8'd14,
        8'd13,  8'd14,  8'd18,  8'd17,  8'd16,  8'd19,  8'd24,  8'd40,
        8'd26,  8'd24,  8'd22,  8'd22,  8'd24,  8'd49,  8'd35,  8'd37,
        8'd29,  8'd40,  8'd58,  8'd51,  8'd61,  8'd60,  8'd57,  8'd51,
        8'd56,  8'd55,  8'd64,  8'd72,  8'd92,  8'd78,  8'd64,  8'd68,
        8'd87,  8'd69,  8'd55,  8'd56,  8'd80,  8'd109, 8'd81,  8'd87,
        8'd95,  8'd98,  8'd103, 8'd104, 8'd103, 8'd62,  8'd77,  8'd113,
        8'd121, 8'd112, 8'd100, 8'd120, 8'd92,  8'd101, 8'd103, 8'd99
    };

    // floor(65536 / d). Every table entry is at least 10, so the
    // result always fits in 16 bits.
    function automatic recip_t qrecip(input logic [7:0] d);
        logic [31:0] r;
        r = 32'd65536 / {24'd0, d};
        return r[15:0];
    endfunction

endpackage

/* design/coef_stream_if.sv */
`include "jenc_settings.svh"

// Quantized coefficients with their zigzag position.
interface coef_stream_if;

    logic signed [`JENC_QW-1:0] coef;
    jenc_pkg::coef_pos_t        pos;
    logic                       frame_last;
    logic                       valid;
    logic                       hold;

    modport src (
        output coef, pos, frame_last, valid,
        input  hold
    );

    modport dst (
        input  coef, pos, frame_last, valid,
        output hold
    );

endinterface

/* design/code_stream_if.sv */
`include "jenc_settings.svh"

// Variable length code words, right aligned in bits.
interface code_stream_if;

    logic [4:0]                  length;
    logic [`JENC_CODE_MAX-1:0]   bits;
    logic                        tlast;
    logic                        valid;
    logic                        hold;

    modport src (
        output length, bits, tlast, valid,
        input  hold
    );

    modport dst (
        input  length, bits, tlast, valid,
        output hold
    );

endinterface

/* design/coef_quant.sv */
`include "jenc_settings.svh"

module coef_quant (
    input  logic signed [`JENC_DW-1:0]  di,
    input  logic                        di_valid,
    input  logic                        di_last,
    output logic                        di_hold,

    coef_stream_if.src                  q,

    input  logic                        clk,
    input  logic                        rst
);

    localparam int PW   = `JENC_DW + 16;
    localparam int QMAX = (1 << (`JENC_QW - 1)) - 1;

    jenc_pkg::recip_t       recip_rom [64];
    jenc_pkg::coef_pos_t    pos;

    logic                   s1_valid;
    logic [`JENC_DW-1:0]    s1_mag;
    logic                   s1_neg;
    jenc_pkg::recip_t       s1_recip;
    jenc_pkg::coef_pos_t    s1_pos;
    logic                   s1_last;

    logic                   adv1;
    logic                   adv2;
    logic                   take;
    logic [PW:0]            prod;
    logic [PW-16:0]         quot;
    logic [`JENC_QW-2:0]    qmag;

    // Reciprocals fold to constants at elaboration.
    for (genvar i = 0; i < 64; i++) begin : g_recip
        assign recip_rom[i] = jenc_pkg::qrecip(jenc_pkg::qtable[i]);
    end

    // Output stage moves when empty or accepted, stage 1 when stage 2 moves.
    assign adv2    = !q.valid || !q.hold;
    assign adv1    = !s1_valid || adv2;
    assign take    = di_valid && adv1;
    assign di_hold = !adv1;

    // ------------------------------
    // Rounded reciprocal multiply
    // ------------------------------
    assign prod = (PW+1)'(s1_mag) * (PW+1)'(s1_recip) + (PW+1)'(32'd32768);
    assign quot = prod[PW:16];
    assign qmag = (quot > (PW-15)'(QMAX)) ? (`JENC_QW-1)'(QMAX) : quot[`JENC_QW-2:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            pos      <= '0;
            s1_valid <= 1'b0;
            q.valid  <= 1'b0;
        end else begin
            if (take) begin
                pos <= di_last ? '0 : pos + 1'b1;
            end
            if (adv1) begin
                s1_valid <= di_valid;
            end
            if (adv2) begin
                q.valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            s1_mag   <= di[`JENC_DW-1] ? `JENC_DW'(-di) : `JENC_DW'(di);
            s1_neg   <= di[`JENC_DW-1];
            s1_recip <= recip_rom[pos];
            s1_pos   <= pos;
            s1_last  <= di_last;
        end
        if (adv2 && s1_valid) begin
            q.coef       <= s1_neg ? -$signed({1'b0, qmag}) : $signed({1'b0, qmag});
            q.pos        <= s1_pos;
            q.frame_last <= s1_last;
        end
    end

endmodule

/* design/run_length_coder.sv */
`include "jenc_settings.svh"

module run_length_coder (
    coef_stream_if.dst  q,
    code_stream_if.src  c,

    input  logic        clk,
    input  logic        rst
);

    localparam int VW = `JENC_QW + 1;
    localparam int CM = `JENC_CODE_MAX;

    logic signed [`JENC_QW-1:0] pred;
    logic [5:0]                 run;

    logic                       is_dc;
    logic                       is_zero;
    logic                       need_zrl;
    logic                       emit_eob;
    logic                       out_free;
    logic                       emit;
    logic                       accept;
    logic signed [VW-1:0]       val;
    logic [VW-1:0]              mag;
    logic [VW-1:0]              amp;
    logic [3:0]                 size;
    logic [7:0]                 sym;
    logic [CM-1:0]              amp_mask;
    logic [CM-1:0]              code_bits;
    logic [4:0]                 code_len;

    // Number of significant bits in a magnitude.
    function automatic logic [3:0] bit_size(input logic [VW-1:0] m);
        logic [3:0] n;
        n = '0;
        for (int i = 0; i < VW; i++) begin
            if (m[i]) begin
                n = 4'(i + 1);
            end
        end
        return n;
    endfunction

    // ------------------------------
    // Symbol and amplitude
    // ------------------------------
    always_comb begin
        is_dc = (q.pos == '0);
        if (is_dc) begin
            val = $signed({q.coef[`JENC_QW-1], q.coef}) - $signed({pred[`JENC_QW-1], pred});
        end else begin
            val = $signed({q.coef[`JENC_QW-1], q.coef});
        end
        is_zero  = (val == '0);
        mag      = val[VW-1] ? -val : val;
        amp      = val[VW-1] ? val - 1'b1 : val;  // one's complement form
        size     = bit_size(mag);
        amp_mask = (CM'(1) << size) - 1'b1;
        sym      = is_dc ? {4'd0, size} : {run[3:0], size};

        need_zrl = !is_dc && !is_zero && (run > 6'd15);
        emit_eob = !is_dc && is_zero && (q.pos == 6'd63);

        if (emit_eob) begin
            code_bits = '0;
            code_len  = 5'd8;
        end else if (need_zrl) begin
            code_bits = CM'(8'hF0);
            code_len  = 5'd8;
        end else begin
            code_bits = (CM'(sym) << size) | (CM'(amp) & amp_mask);
            code_len  = (is_dc ? 5'd4 : 5'd8) + 5'(size);
        end
    end

    // A ZRL word leaves the coefficient waiting upstream.
    assign out_free = !c.valid || !c.hold;
    assign emit     = q.valid && out_free && (is_dc || !is_zero || emit_eob);
    assign accept   = q.valid && out_free && !need_zrl;
    assign q.hold   = !out_free || need_zrl;

    always_ff @(posedge clk) begin
        if (rst) begin
            pred    <= '0;
            run     <= '0;
            c.valid <= 1'b0;
        end else begin
            if (out_free) begin
                c.valid <= emit;
            end
            if (accept) begin
                if (q.frame_last) begin
                    pred <= '0;
                end else if (is_dc) begin
                    pred <= q.coef;
                end
                if (is_dc || !is_zero || q.pos == 6'd63) begin
                    run <= '0;
                end else begin
                    run <= run + 1'b1;
                end
            end else if (emit) begin
                run <= run - 6'd16;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            c.bits   <= code_bits;
            c.length <= code_len;
            c.tlast  <= accept && q.frame_last;
        end
    end

endmodule

/* design/bit_packer.sv */
`include "jenc_settings.svh"

module bit_packer (
    code_stream_if.dst  c,

    output logic [7:0]  byte_data,
    output logic        byte_valid,
    output logic        byte_last,
    input  logic        byte_hold,

    input  logic        clk,
    input  logic        rst
);

    localparam int CM = `JENC_CODE_MAX;

    // Valid bits sit at the top of acc, everything below cnt is zero.
    logic [31:0]    acc;
    logic [5:0]     cnt;
    logic           flush;

    logic           pop;
    logic           take;
    logic [31:0]    acc_shift;
    logic [5:0]     cnt_shift;
    logic [31:0]    code_left;

    // ------------------------------
    // Byte output
    // ------------------------------
    assign byte_valid = (cnt >= 6'd8) || (flush && cnt != '0);
    assign byte_last  = flush && (cnt != '0) && (cnt <= 6'd8);
    assign byte_data  = acc[31:24] | ((flush && cnt < 6'd8) ? (8'hFF >> cnt) : 8'h00);
    assign pop        = byte_valid && !byte_hold;

    // Nothing new enters until the padded tail has left.
    assign c.hold = flush || (7'(cnt) + 7'(c.length) > 7'd32);
    assign take   = c.valid && !c.hold;

    always_comb begin
        acc_shift = pop ? {acc[23:0], 8'h00} : acc;
        if (!pop) begin
            cnt_shift = cnt;
        end else if (cnt >= 6'd8) begin
            cnt_shift = cnt - 6'd8;
        end else begin
            cnt_shift = '0;
        end
        // Move the code word MSB to bit 31.
        code_left = {c.bits, {(32-CM){1'b0}}} << (5'(CM) - c.length);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc   <= '0;
            cnt   <= '0;
            flush <= 1'b0;
        end else begin
            if (take) begin
                acc <= acc_shift | (code_left >> cnt_shift);
                cnt <= cnt_shift + 6'(c.length);
            end else begin
                acc <= acc_shift;
                cnt <= cnt_shift;
            end
            if (take && c.tlast) begin
                flush <= 1'b1;
            end else if (pop && byte_last) begin
                flush <= 1'b0;
            end
        end
    end

endmodule

/* design/byte_stuffer.sv */
`include "jenc_settings.svh"

module byte_stuffer (
    input  logic [7:0]                  byte_data,
    input  logic                        byte_valid,
    input  logic                        byte_last,
    output logic                        byte_hold,

    output logic [31:0]                 out_data,
    output logic [2:0]                  out_bytes,
    output logic                        out_tlast,
    output logic                        out_valid,
    input  logic                        out_hold,

    output logic [`JENC_SIZE_W-1:0]     size,
    input  logic                        size_clear,

    input  logic                        clk,
    input  logic                        rst
);

    // A 0x00 is owed after the last 0xFF taken.
    logic           zero_pend;
    logic           zero_last;

    logic [31:0]    asm_data;
    logic [1:0]     asm_cnt;

    logic [7:0]     s_data;
    logic           s_last;
    logic           s_valid;
    logic           s_take;
    logic           word_done;
    logic           out_free;
    logic [31:0]    merged;

    // ------------------------------
    // Stuffed byte stream
    // ------------------------------
    assign s_data  = zero_pend ? 8'h00 : byte_data;
    assign s_last  = zero_pend ? zero_last : (byte_last && byte_data != 8'hFF);
    assign s_valid = zero_pend || byte_valid;

    // Word closes on its fourth byte or at the end of the frame.
    assign out_free  = !out_valid || !out_hold;
    assign word_done = (asm_cnt == 2'd3) || s_last;
    assign s_take    = s_valid && (!word_done || out_free);
    assign byte_hold = zero_pend || (word_done && !out_free);

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (i < asm_cnt) begin
                merged[31-8*i -: 8] = asm_data[31-8*i -: 8];
            end else if (i == asm_cnt) begin
                merged[31-8*i -: 8] = s_data;
            end else begin
                merged[31-8*i -: 8] = 8'h00;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            zero_pend <= 1'b0;
            asm_cnt   <= '0;
            out_valid <= 1'b0;
            size      <= '0;
        end else begin
            if (s_take) begin
                if (zero_pend) begin
                    zero_pend <= 1'b0;
                end else if (byte_data == 8'hFF) begin
                    zero_pend <= 1'b1;
                end
                asm_cnt <= word_done ? '0 : asm_cnt + 1'b1;
            end
            if (out_free) begin
                out_valid <= s_take && word_done;
            end
            if (size_clear) begin
                size <= '0;
            end else if (out_valid && !out_hold) begin
                size <= size + `JENC_SIZE_W'(out_bytes);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_take) begin
            asm_data <= merged;
            if (!zero_pend) begin
                zero_last <= byte_last;
            end
        end
        if (s_take && word_done) begin
            out_data  <= merged;
            out_bytes <= 3'(asm_cnt) + 3'd1;
            out_tlast <= s_last;
        end
    end

endmodule

/* design/jenc_backend.sv */
`include "jenc_settings.svh"

module jenc_backend (
    input  logic signed [`JENC_DW-1:0]  di,
    input  logic                        di_valid,
    input  logic                        di_last,
    output logic                        di_hold,

    output logic [31:0]                 out_data,
    output logic [2:0]                  out_bytes,
    output logic                        out_tlast,
    output logic                        out_valid,
    input  logic                        out_hold,

    output logic [`JENC_SIZE_W-1:0]     size,
    input  logic                        size_clear,

    input  logic                        clk,
    input  logic                        rst
);

    coef_stream_if  coef_if ();
    code_stream_if  code_if ();

    logic [7:0]     b_data;
    logic           b_valid;
    logic           b_last;
    logic           b_hold;

    coef_quant coef_quant (
        .q          (coef_if),
        .*
    );

    run_length_coder run_length_coder (
        .q          (coef_if),
        .c          (code_if),
        .*
    );

    bit_packer bit_packer (
        .c          (code_if),
        .byte_data  (b_data),
        .byte_valid (b_valid),
        .byte_last  (b_last),
        .byte_hold  (b_hold),
        .*
    );

    byte_stuffer byte_stuffer (
        .byte_data  (b_data),
        .byte_valid (b_valid),
        .byte_last  (b_last),
        .byte_hold  (b_hold),
        .*
    );

endmodule

/* dv/jenc_backend_tb.sv */
`include "jenc_settings.svh"

module jenc_backend_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_BLOCKS      = 4;
    localparam int NUM_BLOCKS      = 1 + 9 + 2 + 2 + 4;
    localparam int WATCHDOG_CYCLES = 400 * NUM_BLOCKS + 1000;

    logic                           clk;
    logic                           rst;
    logic signed [`JENC_DW-1:0]     di;
    logic                           di_valid;
    logic                           di_last;
    logic                           di_hold;
    logic [31:0]                    out_data;
    logic [2:0]                     out_bytes;
    logic                           out_tlast;
    logic                           out_valid;
    logic                           out_hold;
    logic [`JENC_SIZE_W-1:0]        size;
    logic                           size_clear;

    // Frame under test in zigzag order, and the expected byte stream.
    int         frame_coef [MAX_BLOCKS*64];
    int         frame_blocks;
    logic [7:0] exp_q [$];
    int         frame_end_q [$];
    logic [7:0] raw_q [$];
    int         cur_byte;
    int         cur_bits;

    int         frames_sent;
    int         frames_seen;
    int         rx_idx;
    int         rx_since_clear;
    int         lane3_ff;
    int         gap_pct;
    int         hold_pct;
    int         data_errors;
    int         frame_errors;
    int         size_errors;

    jenc_backend DUT (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic int quantize(input int d, input int pos);
        int mag;
        int q;
        mag = (d < 0) ? -d : d;
        q = (mag * int'(jenc_pkg::qrecip(jenc_pkg::qtable[pos])) + 32768) >>> 16;
        if (q > 1023) begin
            q = 1023;
        end
        return (d < 0) ? -q : q;
    endfunction

    function automatic int magnitude_bits(input int v);
        int m;
        int n;
        m = (v < 0) ? -v : v;
        n = 0;
        while (m != 0) begin
            n++;
            m = m >> 1;
        end
        return n;
    endfunction

    function automatic void put_bits(input int value, input int count);
        for (int i = count - 1; i >= 0; i--) begin
            cur_byte = ((cur_byte << 1) | ((value >> i) & 1)) & 8'hFF;
            cur_bits++;
            if (cur_bits == 8) begin
                raw_q.push_back(8'(cur_byte));
                cur_byte = 0;
                cur_bits = 0;
            end
        end
    endfunction

    // Symbol, then amplitude with negative values sent as v - 1.
    function automatic void put_code(input int run, input int v, input bit dc);
        int sz;
        int amp;
        sz  = magnitude_bits(v);
        amp = (v < 0) ? v - 1 : v;
        if (dc) begin
            put_bits(sz, 4);
        end else begin
            put_bits(run * 16 + sz, 8);
        end
        put_bits(amp & ((1 << sz) - 1), sz);
    endfunction

    function automatic void build_expected();
        int qc [64];
        int pred;
        int run;
        pred     = 0;
        cur_byte = 0;
        cur_bits = 0;
        raw_q.delete();
        for (int b = 0; b < frame_blocks; b++) begin
            for (int k = 0; k < 64; k++) begin
                qc[k] = quantize(frame_coef[b*64+k], k);
            end
            put_code(0, qc[0] - pred, 1'b1);
            pred = qc[0];
            run  = 0;
            for (int k = 1; k < 64; k++) begin
                if (qc[k] == 0) begin
                    run++;
                    if (k == 63) begin
                        put_bits(0, 8);
                    end
                end else begin
                    while (run > 15) begin
                        put_bits(8'hF0, 8);
                        run -= 16;
                    end
                    put_code(run, qc[k], 1'b0);
                    run = 0;
                end
            end
        end
        while (cur_bits != 0) begin
            put_bits(1, 1);
        end
        foreach (raw_q[i]) begin
            exp_q.push_back(raw_q[i]);
            if (raw_q[i] == 8'hFF) begin
                exp_q.push_back(8'h00);
            end
        end
        frame_end_q.push_back(exp_q.size());
    endfunction

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic clear_frame(input int blocks);
        frame_blocks = blocks;
        for (int i = 0; i < MAX_BLOCKS * 64; i++) begin
            frame_coef[i] = 0;
        end
    endtask

    task automatic random_frame(input int blocks);
        clear_frame(blocks);
        for (int i = 0; i < blocks * 64; i++) begin
            if (i % 64 == 0) begin
                frame_coef[i] = int'($urandom % 6001) - 3000;
            end else if ($urandom % 100 < 15) begin
                frame_coef[i] = int'($urandom % 3001) - 1500;
            end
        end
    endtask

    // Quantized values of the form 2^s - 1 give long runs of one bits.
    task automatic ones_frame();
        int v;
        int q;
        clear_frame(2);
        for (int i = 0; i < 128; i++) begin
            q = int'(jenc_pkg::qtable[i % 64]);
            v = 1;
            while (q * (2 * v + 1) <= 16383 && 2 * v + 1 <= 1023) begin
                v = 2 * v + 1;
            end
            frame_coef[i] = (i < 64) ? q * v : q * (v >> 1);
        end
    endtask

    task automatic send_coef(input int value, input bit last);
        di       = `JENC_DW'(value);
        di_valid = 1'b1;
        di_last  = last;
        @(negedge clk);
        while (di_hold) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        di_valid = 1'b0;
        di_last  = 1'b0;
        while ($urandom % 100 < gap_pct) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic send_frame();
        build_expected();
        for (int i = 0; i < frame_blocks * 64; i++) begin
            send_coef(frame_coef[i], i == frame_blocks * 64 - 1);
        end
        frames_sent++;
    endtask

    task automatic wait_done();
        while (frames_seen < frames_sent) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        #2;
        if (rx_idx != exp_q.size()) begin
            $display("Output stream holds %0d bytes, but %0d were expected", rx_idx,
                     exp_q.size());
            frame_errors++;
        end
        if (size != `JENC_SIZE_W'(rx_since_clear)) begin
            $display("** Error at %0t: size = %0d, expected %0d", $time, size, rx_since_clear);
            size_errors++;
        end
    endtask

    task automatic clear_size();
        size_clear = 1'b1;
        @(posedge clk);
        #2;
        size_clear     = 1'b0;
        rx_since_clear = 0;
        if (size != '0) begin
            $display("** Error at %0t: size = %0d, expected 0 after size_clear", $time, size);
            size_errors++;
        end
    endtask

    initial begin : hold_driver
        forever begin
            @(posedge clk);
            #2;
            out_hold = ($urandom % 100 < hold_pct);
        end
    end

    // ------------------------------
    // Output monitor
    // ------------------------------
    initial begin : monitor
        logic [7:0] got;
        int         start;
        forever begin
            @(negedge clk);
            if (out_valid && !out_hold) begin
                start = (frames_seen == 0) ? 0 : frame_end_q[frames_seen-1];
                if (out_bytes == 3'd0 || out_bytes > 3'd4 || (!out_tlast && out_bytes != 3'd4)) begin
                    $display("Output word at %0t carries %0d bytes outside a frame end",
                             $time, out_bytes);
                    frame_errors++;
                end
                for (int i = 0; i < int'(out_bytes) && i < 4; i++) begin
                    got = out_data[31-8*i -: 8];
                    if (rx_idx >= exp_q.size()) begin
                        $display("Unexpected byte 0x%02h at %0t past the expected stream",
                                 got, $time);
                        data_errors++;
                    end else if (got != exp_q[rx_idx]) begin
                        $display("** Error at %0t: out_data byte %0d = 0x%02h, expected 0x%02h",
                                 $time, rx_idx, got, exp_q[rx_idx]);
                        data_errors++;
                    end
                    if (got == 8'hFF && (rx_idx - start) % 4 == 3) begin
                        lane3_ff++;
                    end
                    rx_idx++;
                    rx_since_clear++;
                end
                if (frames_seen >= frame_end_q.size()) begin
                    $display("Output word at %0t arrived with no frame outstanding", $time);
                    frame_errors++;
                end else if (out_tlast && rx_idx != frame_end_q[frames_seen]) begin
                    $display("out_tlast came at byte %0d, but frame %0d ends at byte %0d",
                             rx_idx, frames_seen, frame_end_q[frames_seen]);
                    frame_errors++;
                end else if (!out_tlast && rx_idx >= frame_end_q[frames_seen]) begin
                    $display("out_tlast is missing at the end of frame %0d", frames_seen);
                    frame_errors++;
                end
                if (out_tlast || (frames_seen < frame_end_q.size() &&
                                  rx_idx >= frame_end_q[frames_seen])) begin
                    frames_seen++;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, %0d of %0d frames received",
                 WATCHDOG_CYCLES, frames_seen, frames_sent);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : main
        void'($urandom(32'h0a86dac2));
        rst        = 1'b1;
        di         = '0;
        di_valid   = 1'b0;
        di_last    = 1'b0;
        out_hold   = 1'b0;
        size_clear = 1'b0;
        gap_pct    = 0;
        hold_pct   = 0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        // DC only, so the stream is DC code, EOB and padding.
        clear_frame(1);
        frame_coef[0] = 40;
        send_frame();
        wait_done();
        clear_size();

        repeat (3) begin
            random_frame(3);
            send_frame();
        end
        wait_done();
        clear_size();

        // Runs of 39 and 60 zeros need ZRL words.
        clear_frame(2);
        frame_coef[0]   = 500;
        frame_coef[20]  = 300;
        frame_coef[60]  = -400;
        frame_coef[64]  = -800;
        frame_coef[66]  = 50;
        frame_coef[127] = 900;
        send_frame();
        wait_done();
        clear_size();

        ones_frame();
        send_frame();
        wait_done();
        clear_size();

        gap_pct  = 30;
        hold_pct = 40;
        repeat (2) begin
            random_frame(2);
            send_frame();
        end
        wait_done();
        clear_size();

        if (lane3_ff == 0) begin
            $display("No 0xFF byte was seen in the last lane of an output word");
            frame_errors++;
        end
        $display("Errors: %0d data, %0d framing, %0d size", data_errors, frame_errors,
                 size_errors);
        if (data_errors + frame_errors + size_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* jenc_backend.f */
+incdir+design
design/jenc_pkg.sv
design/coef_stream_if.sv
design/code_stream_if.sv
design/coef_quant.sv
design/run_length_coder.sv
design/bit_packer.sv
design/byte_stuffer.sv
design/jenc_backend.sv
dv/jenc_backend_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
    -f jenc_backend.f --top-module jenc_backend_tb --Mdir obj_dir

out=$(./obj_dir/Vjenc_backend_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'TESTS PASSED'; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed"
exit 1
